// File: Makefile
# Verilator build and run for the request arbiter testbench

VERILATOR ?= verilator
TOP       ?= tb_req_arbiter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: req_arb_fsm.sv
`default_nettype none

// packet level control for the arbiter
// a channel keeps the output from its first beat to its last, then the
// scan gets a fresh say
module req_arb_fsm (
    input  wire                       dma_clk,
    input  wire                       rst_n,
    input  req_arb_pkg::chnl_idx_t    next_chnl,   // live pick from the scan
    input  wire                       any_valid,   // some channel is requesting
    input  wire                       beat_done,   // last beat accepted at the output
    output req_arb_pkg::chnl_idx_t    grant,       // channel routed to the output
    output logic                      active       // output path open
);

    req_arb_pkg::arb_state_t cur_state;
    req_arb_pkg::arb_state_t nxt_state;

    req_arb_pkg::chnl_idx_t  grant_reg;            // frozen grant for req_trans

    logic is_schedule;
    logic is_req_trans;
    logic to_req_trans;                            // schedule -> req_trans this cycle

    // ******************************************************************
    // state decode
    // ******************************************************************
    assign is_schedule  = (cur_state == req_arb_pkg::schedule);
    assign is_req_trans = (cur_state == req_arb_pkg::req_trans);

    // a packet is under way and didn't finish in its first cycle,
    // so the pick must be locked before the scan moves on
    assign to_req_trans = is_schedule & ~beat_done & any_valid;

    // ******************************************************************
    // state register
    // ******************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_state <= req_arb_pkg::idle;
        end else begin
            cur_state <= nxt_state;
        end
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_reg <= '0;
        end else if (to_req_trans) begin
            grant_reg <= next_chnl;        // capture the channel we are serving
        end
    end

    // ******************************************************************
    // next state
    // ******************************************************************
    always_comb begin
        nxt_state = cur_state;
        unique case (cur_state)
            req_arb_pkg::idle: begin
                if (any_valid) begin
                    nxt_state = req_arb_pkg::schedule;
                end
            end
            req_arb_pkg::schedule: begin
                if (beat_done) begin
                    nxt_state = req_arb_pkg::schedule;   // single beat packet, pick again
                end else if (any_valid) begin
                    nxt_state = req_arb_pkg::req_trans;  // hold the channel
                end else begin
                    nxt_state = req_arb_pkg::idle;
                end
            end
            req_arb_pkg::req_trans: begin
                if (beat_done) begin
                    nxt_state = req_arb_pkg::schedule;   // packet closed
                end
            end
            default: begin
                nxt_state = req_arb_pkg::idle;           // illegal encoding recovers here
            end
        endcase
    end

    // ******************************************************************
    // outputs
    // ******************************************************************
    // in schedule the pick goes straight out, no extra cycle
    assign grant  = is_schedule ? next_chnl : grant_reg;
    assign active = is_schedule | is_req_trans;

endmodule

`default_nettype wire

// File: req_arb_pkg.sv
`default_nettype none

package req_arb_pkg;

    // ******************************************************************
    // stream geometry
    // ******************************************************************
    localparam int chnl_num     = 4;    // request channels into the arbiter
    localparam int chnl_idx_w   = 2;    // enough bits to name one channel
    localparam int dma_data_w   = 64;   // payload per beat
    localparam int dma_keep_w   = dma_data_w / 8;   // one enable per byte
    localparam int axis_tuser_w = 128;  // request header, first beat only

    // channel number as carried between scan, fsm and output mux
    typedef logic [chnl_idx_w-1:0] chnl_idx_t;

    // ******************************************************************
    // one stream beat
    // ******************************************************************
    // user holds the dma request header. two layouts share it
    //   normal request : type 107:104, tag 103:96, addr 95:32,
    //                    dw length 18:8, first be 7:4, last be 3:0
    //   interrupt req  : type 107:104, addr 95:32, rest reserved
    // the arbiter never looks inside, it only forwards the word
    typedef struct packed {
        logic                    last;  // final beat of the packet
        logic [dma_data_w-1:0]   data;  // payload
        logic [dma_keep_w-1:0]   keep;  // byte enables
        logic [axis_tuser_w-1:0] user;  // header, don't care after beat 0
    } req_beat_t;

    // ******************************************************************
    // arbiter states, one-hot
    // ******************************************************************
    // idle      : nothing pending, outputs quiet
    // schedule  : grant follows the live round-robin pick
    // req_trans : grant frozen until the packet's last beat leaves
    typedef enum logic [2:0] {
        idle      = 3'b001,
        schedule  = 3'b010,
        req_trans = 3'b100
    } arb_state_t;

endpackage

`default_nettype wire

// File: req_arbiter.sv
`default_nettype none

// round-robin packet arbiter for dma request streams
// chnl_num input streams merged into one, packets never interleaved
module req_arbiter (
    input  wire                       dma_clk,
    input  wire                       rst_n,

    // ******************************************************************
    // slave streams, one per request channel
    // ******************************************************************
    input  req_arb_pkg::req_beat_t    s_req_beat [req_arb_pkg::chnl_num],
    input  wire [req_arb_pkg::chnl_num-1:0] s_req_valid,
    output logic [req_arb_pkg::chnl_num-1:0] s_req_ready,

    // ******************************************************************
    // master stream towards the request engine
    // ******************************************************************
    output req_arb_pkg::req_beat_t    m_req_beat,   // header in user on first beat
    output logic                      m_req_valid,
    input  wire                       m_req_ready
);

    req_arb_pkg::chnl_idx_t next_chnl;   // scan -> fsm
    logic                   any_valid;   // scan -> fsm
    req_arb_pkg::chnl_idx_t grant;       // fsm -> mux, scan
    logic                   active;      // fsm -> mux
    logic                   beat_done;   // mux -> fsm, scan

    // who goes next
    req_rr_scan u_rr_scan (
        .dma_clk     (dma_clk),
        .rst_n       (rst_n),
        .s_req_valid (s_req_valid),
        .grant       (grant),
        .beat_done   (beat_done),
        .next_chnl   (next_chnl),
        .any_valid   (any_valid)
    );

    // packet ownership
    req_arb_fsm u_arb_fsm (
        .dma_clk     (dma_clk),
        .rst_n       (rst_n),
        .next_chnl   (next_chnl),
        .any_valid   (any_valid),
        .beat_done   (beat_done),
        .grant       (grant),
        .active      (active)
    );

    // steer data and ready
    req_out_mux u_out_mux (
        .s_req_beat  (s_req_beat),
        .s_req_valid (s_req_valid),
        .grant       (grant),
        .active      (active),
        .m_req_ready (m_req_ready),
        .s_req_ready (s_req_ready),
        .m_req_beat  (m_req_beat),
        .m_req_valid (m_req_valid),
        .beat_done   (beat_done)
    );

endmodule

`default_nettype wire

// File: req_arbiter_props.sv
`default_nettype none

// stream checks for the request arbiter
// bound onto req_arbiter, sees only its ports
module req_arbiter_props (
    input  wire                             dma_clk,
    input  wire                             rst_n,
    input  req_arb_pkg::req_beat_t          s_req_beat [req_arb_pkg::chnl_num],
    input  wire [req_arb_pkg::chnl_num-1:0] s_req_valid,
    input  wire [req_arb_pkg::chnl_num-1:0] s_req_ready,
    input  req_arb_pkg::req_beat_t          m_req_beat,
    input  wire                             m_req_valid,
    input  wire                             m_req_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned            fail_cnt = 0;  // read by the testbench
    logic                   acc;           // output handshake this cycle
    req_arb_pkg::chnl_idx_t acc_chnl;      // channel named in the output data
    req_arb_pkg::req_beat_t src_beat;      // that channel's beat at the input
    logic                   src_ready;
    logic                   in_pkt;        // last accepted beat was not last
    logic                   held;          // output valid but refused last cycle
    logic [7:0]             cur_chnl;      // channel of the packet in flight
    req_arb_pkg::chnl_idx_t rr_prev;       // channel of the previous packet
    logic [3:0]             exp_beat;      // beat number due next

    // first valid channel after prev, wrapping; prev itself comes last
    function automatic req_arb_pkg::chnl_idx_t rr_expect(
        input req_arb_pkg::chnl_idx_t           prev,
        input logic [req_arb_pkg::chnl_num-1:0] vld
    );
        int   cand;
        logic found;
        rr_expect = prev;
        found     = 1'b0;
        for (int k = 1; k <= req_arb_pkg::chnl_num; k++) begin
            cand = (int'(prev) + k) % req_arb_pkg::chnl_num;   // step forward around the ring
            if (!found && vld[cand]) begin
                rr_expect = req_arb_pkg::chnl_idx_t'(cand);
                found     = 1'b1;                           // nearest one wins
            end
        end
    endfunction

    assign acc       = m_req_valid & m_req_ready;
    assign acc_chnl  = m_req_beat.data[req_arb_pkg::chnl_idx_w-1:0];
    assign src_beat  = s_req_beat[acc_chnl];
    assign src_ready = s_req_ready[acc_chnl];

    // ******************************************************************
    // packet tracking
    // ******************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            held     <= 1'b0;
            cur_chnl <= '0;
            rr_prev  <= '0;                 // first packet counts from channel 0
            exp_beat <= '0;
        end else begin
            held <= m_req_valid & ~m_req_ready;
            if (acc) begin
                cur_chnl <= m_req_beat.data[7:0];
                in_pkt   <= ~m_req_beat.last;
                exp_beat <= m_req_beat.last ? 4'd0 : exp_beat + 4'd1;
                if (m_req_beat.last) begin
                    rr_prev <= acc_chnl;   // packet closed
                end
            end
        end
    end

    // ******************************************************************
    // properties
    // ******************************************************************
    a_reset_quiet: assert property (@(posedge dma_clk)
        (!rst_n || !$past(rst_n)) |-> (!m_req_valid && s_req_ready == '0))
        else begin fail_cnt = fail_cnt + 1; $error("output active around reset"); end

    a_no_interleave: assert property (@(posedge dma_clk) disable iff (!rst_n)
        (acc && in_pkt) |-> m_req_beat.data[7:0] == cur_chnl)
        else begin fail_cnt = fail_cnt + 1; $error("packets interleaved"); end

    a_rr_order: assert property (@(posedge dma_clk) disable iff (!rst_n)
        (m_req_valid && !in_pkt && !held)
            |-> m_req_beat.data[7:0] == 8'(rr_expect(rr_prev, s_req_valid)))
        else begin fail_cnt = fail_cnt + 1; $error("round-robin order broken"); end

    a_beat_matches: assert property (@(posedge dma_clk) disable iff (!rst_n)
        acc |-> (m_req_beat.data[7:req_arb_pkg::chnl_idx_w] == '0
                 && m_req_beat == src_beat && src_ready))
        else begin fail_cnt = fail_cnt + 1; $error("output beat differs from source"); end

    a_beat_order: assert property (@(posedge dma_clk) disable iff (!rst_n)
        acc |-> m_req_beat.keep[3:0] == exp_beat)
        else begin fail_cnt = fail_cnt + 1; $error("beat numbers out of sequence"); end

    a_ready_gated: assert property (@(posedge dma_clk) disable iff (!rst_n)
        (m_req_ready || s_req_ready == '0) && $onehot0(s_req_ready))
        else begin fail_cnt = fail_cnt + 1; $error("ready leaked to a source"); end

    a_hold_stalled: assert property (@(posedge dma_clk) disable iff (!rst_n)
        $past(m_req_valid && !m_req_ready)
            |-> (m_req_valid && m_req_beat == $past(m_req_beat)))
        else begin fail_cnt = fail_cnt + 1; $error("stalled beat changed"); end

endmodule

bind req_arbiter req_arbiter_props u_props (
    .dma_clk     (dma_clk),
    .rst_n       (rst_n),
    .s_req_beat  (s_req_beat),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .m_req_beat  (m_req_beat),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready)
);

`default_nettype wire

// File: req_out_mux.sv
`default_nettype none

// output side of the arbiter
// routes the granted channel to the master stream and returns ready only
// to that channel
module req_out_mux (
    input  req_arb_pkg::req_beat_t    s_req_beat [req_arb_pkg::chnl_num],
    input  wire [req_arb_pkg::chnl_num-1:0] s_req_valid,
    input  req_arb_pkg::chnl_idx_t    grant,        // selected channel
    input  wire                       active,       // fsm in schedule or req_trans
    input  wire                       m_req_ready,  // sink can take a beat
    output logic [req_arb_pkg::chnl_num-1:0] s_req_ready,
    output req_arb_pkg::req_beat_t    m_req_beat,
    output logic                      m_req_valid,
    output logic                      beat_done     // packet's last beat left this cycle
);

    req_arb_pkg::req_beat_t sel_beat;   // granted channel's beat, ungated
    logic                   sel_valid;

    // ******************************************************************
    // data path
    // ******************************************************************
    assign sel_beat  = s_req_beat[grant];
    assign sel_valid = s_req_valid[grant];

    // quiet bus while idle, so no stale header leaks downstream
    assign m_req_beat  = active ? sel_beat : '0;
    assign m_req_valid = active & sel_valid;

    // ******************************************************************
    // ready fan-out
    // ******************************************************************
    always_comb begin
        s_req_ready        = '0;
        s_req_ready[grant] = active & m_req_ready;  // only the owner sees the sink
    end

    // end of packet marker for fsm and scan
    assign beat_done = m_req_valid & m_req_ready & m_req_beat.last;

endmodule

`default_nettype wire

// File: req_rr_scan.sv
`default_nettype none

// round-robin pick over the request channels
// the search starts one past the channel served last and wraps around
module req_rr_scan (
    input  wire                       dma_clk,
    input  wire                       rst_n,
    input  wire [req_arb_pkg::chnl_num-1:0] s_req_valid,  // raw valids, one per channel
    input  req_arb_pkg::chnl_idx_t    grant,              // channel owning the output
    input  wire                       beat_done,          // last beat accepted this cycle
    output req_arb_pkg::chnl_idx_t    next_chnl,          // combinational pick
    output logic                      any_valid
);

    req_arb_pkg::chnl_idx_t                last_chnl;  // channel of the last finished packet

    req_arb_pkg::chnl_idx_t                rot_idx  [req_arb_pkg::chnl_num]; // k-th in line
    logic [req_arb_pkg::chnl_num-1:0]      rot_valid;  // valids in priority order

    // ******************************************************************
    // last served channel
    // ******************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_chnl <= '0;               // channel 1 gets first pick after reset
        end else if (beat_done) begin
            last_chnl <= grant;            // packet closed, move the pointer
        end
    end

    // ******************************************************************
    // rotate the valid vector
    // ******************************************************************
    // slot 0 is the channel right after last_chnl, slot chnl_num-1 is
    // last_chnl itself so it only wins when nobody else is waiting
    for (genvar k = 0; k < req_arb_pkg::chnl_num; k++) begin : g_rot
        // the index is exactly chnl_idx_w bits wide so the add wraps at chnl_num
        assign rot_idx[k]   = last_chnl + req_arb_pkg::chnl_idx_t'(k + 1);
        assign rot_valid[k] = s_req_valid[rot_idx[k]];
    end

    // ******************************************************************
    // first set slot wins
    // ******************************************************************
    always_comb begin
        next_chnl = rot_idx[0];            // nobody valid, point past last served
        // walk from the back so the lowest slot overrides
        for (int i = req_arb_pkg::chnl_num - 1; i >= 0; i--) begin
            if (rot_valid[i]) begin
                next_chnl = rot_idx[i];
            end
        end
    end

    assign any_valid = |s_req_valid;       // rotation doesn't change the or

endmodule

`default_nettype wire

// File: sim.f
req_arb_pkg.sv
req_rr_scan.sv
req_arb_fsm.sv
req_out_mux.sv
req_arbiter.sv
req_arbiter_props.sv
tb_req_arbiter.sv

// File: tb_req_arbiter.sv
`default_nettype none

// testbench for the round-robin request arbiter
// random packet sources on every channel, random sink stalls
module tb_req_arbiter;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int chnl_num        = req_arb_pkg::chnl_num;
    localparam int clk_period      = 40;
    localparam int pkts_per_chnl   = 16;
    localparam int max_len         = 4;    // beats per packet, upper bound
    localparam int stall_per_beat  = 10;   // sink stalls, gaps and arbitration turnaround
    localparam int total_pkts      = chnl_num * pkts_per_chnl;
    localparam int watchdog_cycles = total_pkts * max_len * stall_per_beat + 100;
    localparam int stall_limit     = 60;   // cycles with no accepted beat
    localparam logic [31:0] lfsr_seed = 32'd66490;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;   // x^32+x^22+x^2+x+1

    logic                      dma_clk = 1'b0;
    logic                      rst_n;
    req_arb_pkg::req_beat_t    s_req_beat [chnl_num];
    logic [chnl_num-1:0]       s_req_valid;
    logic [chnl_num-1:0]       s_req_ready;
    req_arb_pkg::req_beat_t    m_req_beat;
    logic                      m_req_valid;
    logic                      m_req_ready;

    logic [31:0] lfsr_state = lfsr_seed;
    int          beats_sent = 0;
    int          beats_rcvd = 0;
    int          pkts_rcvd  = 0;

    req_arbiter DUT (
        .dma_clk     (dma_clk),
        .rst_n       (rst_n),
        .s_req_beat  (s_req_beat),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .m_req_beat  (m_req_beat),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready)
    );

    always #(clk_period / 2) dma_clk = ~dma_clk;

    // ******************************************************************
    // helpers
    // ******************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? lfsr_taps : 32'h0);
    endfunction

    // one lfsr step per bit, first bit ends up highest
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // channel in data 7:0, packet count above it, beat number in keep 3:0
    function automatic req_arb_pkg::req_beat_t make_beat(
        input int c, input int pkt, input int beat, input int len, input logic [31:0] rnd
    );
        req_arb_pkg::req_beat_t b;
        b.last = (beat == len - 1);
        b.data = {rnd, 8'h00, 16'(pkt), 8'(c)};
        b.keep = {4'hf, 4'(beat)};
        b.user = (beat == 0) ? {4{rnd}} : '0;   // header on the first beat only
        return b;
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    // checker assertions bump this count
    always @(negedge dma_clk) begin
        if (DUT.u_props.fail_cnt != 0) begin
            report_fail("a stream assertion failed, see the message above");
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        report_fail("watchdog expired before all packets reached the sink");
    end

    // ******************************************************************
    // sources and sink
    // ******************************************************************
    initial begin : stimulus
        logic [31:0] rnd;
        int          pkt_cnt [chnl_num];
        int          beat_no [chnl_num];
        int          pkt_len [chnl_num];
        int          gap     [chnl_num];
        int          idle_cycles;

        rst_n       <= 1'b0;
        s_req_valid <= '0;
        m_req_ready <= 1'b0;
        idle_cycles = 0;
        for (int c = 0; c < chnl_num; c++) begin
            s_req_beat[c] <= '0;
            pkt_cnt[c] = 0;
            beat_no[c] = 0;
            pkt_len[c] = 1;
            gap[c]     = c;                 // staggered start
        end
        repeat (3) @(posedge dma_clk);
        rst_n <= 1'b1;

        while (pkts_rcvd < total_pkts) begin
            @(posedge dma_clk);
            if (m_req_valid && m_req_ready) begin   // sink side handshake
                beats_rcvd++;
                idle_cycles = 0;
                if (m_req_beat.last) begin
                    pkts_rcvd++;
                end
            end else begin
                idle_cycles++;
            end
            if (idle_cycles > stall_limit) begin
                report_fail($sformatf("no beat accepted for %0d cycles", idle_cycles));
            end
            for (int c = 0; c < chnl_num; c++) begin
                if (s_req_valid[c] && s_req_ready[c]) begin
                    beats_sent++;
                    if (beat_no[c] == pkt_len[c] - 1) begin
                        pkt_cnt[c]++;
                        s_req_valid[c] <= 1'b0;
                        take_bits(2, rnd);
                        gap[c] = int'(rnd[1:0]);
                    end else begin
                        beat_no[c]++;
                        take_bits(32, rnd);
                        s_req_beat[c] <= make_beat(c, pkt_cnt[c], beat_no[c], pkt_len[c], rnd);
                    end
                end else if (!s_req_valid[c] && pkt_cnt[c] < pkts_per_chnl) begin
                    if (gap[c] == 0) begin
                        take_bits(2, rnd);
                        pkt_len[c] = 1 + int'(rnd[1:0]);
                        beat_no[c] = 0;
                        take_bits(32, rnd);
                        s_req_beat[c]  <= make_beat(c, pkt_cnt[c], 0, pkt_len[c], rnd);
                        s_req_valid[c] <= 1'b1;
                    end else begin
                        gap[c]--;
                    end
                end
            end
            take_bits(2, rnd);
            m_req_ready <= (rnd[1:0] != 2'b00);   // ready about three cycles in four
        end

        repeat (4) @(posedge dma_clk);
        if (DUT.u_props.fail_cnt != 0) begin
            report_fail("a stream assertion failed, see the message above");
        end else if (beats_rcvd != beats_sent) begin
            report_fail($sformatf("[ERROR] beat_count: expected %0d, actual %0d",
                                  beats_sent, beats_rcvd));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
